// File: source/dhcp_rx_macros.svh
`ifndef DHCP_RX_MACROS_SVH
`define DHCP_RX_MACROS_SVH

// --------------------------------------------------
// bootp header layout, byte 0 is op
// --------------------------------------------------
`define DHCP_OP_REPLY       8'h02   // op byte of a server reply
`define DHCP_XID_FIRST      4       // xid, bytes 4..7
`define DHCP_YIADDR_FIRST   16      // offered address, bytes 16..19
`define DHCP_CHADDR_FIRST   28      // client mac, bytes 28..33
`define DHCP_HEADER_LAST    239     // last byte before the option list

// --------------------------------------------------
// option list
// --------------------------------------------------
`define DHCP_OPT_PAD        8'h00   // single byte, no length
`define DHCP_OPT_END        8'hFF   // closes the list
`define DHCP_OPT_LEASE      8'd51   // lease time, seconds
`define DHCP_OPT_MSG_TYPE   8'd53   // one byte message type
`define DHCP_OPT_SERVER_ID  8'd54   // server ip

// message type values
`define DHCP_MSG_OFFER      8'd2
`define DHCP_MSG_ACK        8'd5

// destination used until a server is known
`define BROADCAST_MAC       48'hFFFF_FFFF_FFFF
`define BROADCAST_IP        32'hFFFF_FFFF

`endif

// File: source/dhcp_rx_pkg.sv
package dhcp_rx_pkg;

  // --------------------------------------------------
  // vector types
  // --------------------------------------------------
  typedef logic [7:0]  octet_t;       // one udp payload byte
  typedef logic [47:0] mac_addr_t;    // ethernet address
  typedef logic [31:0] ip_addr_t;     // ipv4 address
  typedef logic [31:0] seconds_t;     // lease time
  typedef logic [31:0] xid_t;         // transaction id
  typedef logic [7:0]  byte_index_t;  // header position or option count

  // packet walk
  typedef enum logic [2:0] {
    RX_IDLE,       // waiting for op byte
    RX_HEADER,     // fixed 240 byte header
    RX_OPT_CODE,   // option code, pad or end
    RX_OPT_LEN,    // option length byte
    RX_OPT_VALUE,  // option value bytes
    RX_DONE        // rest of packet ignored
  } rx_state_t;

  // one received byte with its strobe
  typedef struct packed {
    octet_t data;
    logic   strobe;  // rx_enable and dhcp_rx_active both high
  } rx_beat_t;

  // options kept from the current packet
  typedef struct packed {
    seconds_t lease;      // option 51
    ip_addr_t server_ip;  // option 54
    octet_t   msg_type;   // option 53
  } dhcp_options_t;

endpackage

// File: source/dhcp_rx_fsm.sv
`timescale 1ns/10ps
`include "dhcp_rx_macros.svh"

module dhcp_rx_fsm (
  input  logic                  rx_clock,
  input  logic                  state_reset,
  input  logic                  dhcp_rx_active,
  input  dhcp_rx_pkg::rx_beat_t beat,
  input  logic                  header_last,  // byte 239 on this beat
  input  logic                  header_ok,    // xid and chaddr matched
  input  logic                  value_last,   // last value byte on this beat
  output dhcp_rx_pkg::rx_state_t state,
  output logic                  packet_end    // end option seen
);

  dhcp_rx_pkg::rx_state_t next_state;

  // --------------------------------------------------
  // next state, only moves on a strobed byte
  // --------------------------------------------------
  always_comb begin
    next_state = state;
    if (beat.strobe) begin
      case (state)
        dhcp_rx_pkg::RX_IDLE:
          if (beat.data == `DHCP_OP_REPLY) next_state = dhcp_rx_pkg::RX_HEADER;
        dhcp_rx_pkg::RX_HEADER:
          if (header_last) begin
            // a foreign reply is ignored to its end
            next_state = header_ok ? dhcp_rx_pkg::RX_OPT_CODE : dhcp_rx_pkg::RX_DONE;
          end
        dhcp_rx_pkg::RX_OPT_CODE:
          if (beat.data == `DHCP_OPT_END) next_state = dhcp_rx_pkg::RX_DONE;
          else if (beat.data != `DHCP_OPT_PAD) next_state = dhcp_rx_pkg::RX_OPT_LEN;
        dhcp_rx_pkg::RX_OPT_LEN:
          // zero length option has no value bytes
          if (beat.data == 8'd0) next_state = dhcp_rx_pkg::RX_OPT_CODE;
          else next_state = dhcp_rx_pkg::RX_OPT_VALUE;
        dhcp_rx_pkg::RX_OPT_VALUE:
          if (value_last) next_state = dhcp_rx_pkg::RX_OPT_CODE;
        dhcp_rx_pkg::RX_DONE:
          next_state = dhcp_rx_pkg::RX_DONE;  // left only when active falls
        default:
          next_state = dhcp_rx_pkg::RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge rx_clock) begin
    if (state_reset) begin
      state <= dhcp_rx_pkg::RX_IDLE;
    end else if (!dhcp_rx_active) begin
      state <= dhcp_rx_pkg::RX_IDLE;  // partial packet dropped
    end else begin
      state <= next_state;
    end
  end

  // decision pulse, registered downstream on this same edge
  assign packet_end = beat.strobe && (state == dhcp_rx_pkg::RX_OPT_CODE) &&
                      (beat.data == `DHCP_OPT_END);

endmodule

// File: source/dhcp_byte_counter.sv
`timescale 1ns/10ps
`include "dhcp_rx_macros.svh"

module dhcp_byte_counter (
  input  logic                   rx_clock,
  input  logic                   state_reset,
  input  dhcp_rx_pkg::rx_beat_t  beat,
  input  dhcp_rx_pkg::rx_state_t state,
  output logic                   header_last,
  output logic                   value_last
);

  // header index while in the header, remaining value bytes in options
  dhcp_rx_pkg::byte_index_t count;

  always_ff @(posedge rx_clock) begin
    if (state_reset) begin
      count <= 8'd1;
    end else if (beat.strobe) begin
      case (state)
        dhcp_rx_pkg::RX_IDLE:      count <= 8'd1;          // op is byte 0
        dhcp_rx_pkg::RX_HEADER:    count <= count + 8'd1;
        dhcp_rx_pkg::RX_OPT_LEN:   count <= beat.data;     // value byte count
        dhcp_rx_pkg::RX_OPT_VALUE: count <= count - 8'd1;
        default:                   count <= count;
      endcase
    end
  end

  // --------------------------------------------------
  // flags for the byte on the current beat
  // --------------------------------------------------
  assign header_last = beat.strobe && (state == dhcp_rx_pkg::RX_HEADER) &&
                       (count == 8'(`DHCP_HEADER_LAST));
  assign value_last  = beat.strobe && (state == dhcp_rx_pkg::RX_OPT_VALUE) &&
                       (count == 8'd1);

endmodule

// File: source/dhcp_header_check.sv
`timescale 1ns/10ps
`include "dhcp_rx_macros.svh"

module dhcp_header_check (
  input  logic                    rx_clock,
  input  logic                    state_reset,
  input  dhcp_rx_pkg::rx_beat_t   beat,
  input  dhcp_rx_pkg::rx_state_t  state,
  input  dhcp_rx_pkg::xid_t       xid,
  input  dhcp_rx_pkg::mac_addr_t  local_mac,
  output logic                    header_ok,
  output dhcp_rx_pkg::ip_addr_t   offered_ip
);

  dhcp_rx_pkg::byte_index_t pos;       // header byte on this beat
  logic                     mismatch;  // sticky for the packet
  logic [1:0]               xid_lane;  // byte lane, 3 is msb
  logic [2:0]               mac_lane;  // byte lane, 5 is msb
  logic [1:0]               ip_lane;
  logic                     in_xid;
  logic                     in_yiaddr;
  logic                     in_chaddr;

  // --------------------------------------------------
  // field windows, network byte order
  // --------------------------------------------------
  assign in_xid    = (pos >= 8'(`DHCP_XID_FIRST))    && (pos < 8'(`DHCP_XID_FIRST + 4));
  assign in_yiaddr = (pos >= 8'(`DHCP_YIADDR_FIRST)) && (pos < 8'(`DHCP_YIADDR_FIRST + 4));
  assign in_chaddr = (pos >= 8'(`DHCP_CHADDR_FIRST)) && (pos < 8'(`DHCP_CHADDR_FIRST + 6));
  assign xid_lane  = 2'(8'(`DHCP_XID_FIRST + 3) - pos);
  assign ip_lane   = 2'(8'(`DHCP_YIADDR_FIRST + 3) - pos);
  assign mac_lane  = 3'(8'(`DHCP_CHADDR_FIRST + 5) - pos);

  always_ff @(posedge rx_clock) begin
    if (state_reset) begin
      pos      <= 8'd1;
      mismatch <= 1'b0;
    end else if (beat.strobe) begin
      if (state == dhcp_rx_pkg::RX_IDLE) begin
        pos      <= 8'd1;   // fresh packet
        mismatch <= 1'b0;
      end else if (state == dhcp_rx_pkg::RX_HEADER) begin
        pos <= pos + 8'd1;
        if (in_xid && (beat.data != xid[8*xid_lane +: 8])) mismatch <= 1'b1;
        if (in_chaddr && (beat.data != local_mac[8*mac_lane +: 8])) mismatch <= 1'b1;
      end
    end
  end

  // offered address, only used after a good header
  always_ff @(posedge rx_clock) begin
    if (beat.strobe && (state == dhcp_rx_pkg::RX_HEADER) && in_yiaddr) begin
      offered_ip[8*ip_lane +: 8] <= beat.data;
    end
  end

  assign header_ok = !mismatch;

endmodule

// File: source/dhcp_option_decode.sv
`timescale 1ns/10ps
`include "dhcp_rx_macros.svh"

module dhcp_option_decode (
  input  logic                       rx_clock,
  input  logic                       state_reset,
  input  dhcp_rx_pkg::rx_beat_t      beat,
  input  dhcp_rx_pkg::rx_state_t     state,
  input  logic                       value_last,
  output dhcp_rx_pkg::dhcp_options_t options
);

  dhcp_rx_pkg::octet_t opt_code;   // code of the option being read
  logic [31:0]         value_sr;   // value bytes, msb first
  logic [31:0]         value_now;  // including the byte on this beat

  assign value_now = {value_sr[23:0], beat.data};

  // --------------------------------------------------
  // code and value shift
  // --------------------------------------------------
  always_ff @(posedge rx_clock) begin
    if (beat.strobe) begin
      if (state == dhcp_rx_pkg::RX_OPT_CODE) opt_code <= beat.data;
      if (state == dhcp_rx_pkg::RX_OPT_VALUE) value_sr <= value_now;
    end
  end

  // --------------------------------------------------
  // kept options
  // --------------------------------------------------
  always_ff @(posedge rx_clock) begin
    if (state_reset) begin
      options <= '0;
    end else if (beat.strobe) begin
      if ((state == dhcp_rx_pkg::RX_IDLE) && (beat.data == `DHCP_OP_REPLY)) begin
        options.msg_type <= '0;  // no stale type from an older packet
      end else if (value_last) begin
        case (opt_code)
          `DHCP_OPT_LEASE:     options.lease     <= value_now;
          `DHCP_OPT_SERVER_ID: options.server_ip <= value_now;
          `DHCP_OPT_MSG_TYPE:  options.msg_type  <= beat.data;  // one byte value
          default:             options           <= options;    // unknown, skipped
        endcase
      end
    end
  end

endmodule

// File: source/dhcp_lease_record.sv
`timescale 1ns/10ps
`include "dhcp_rx_macros.svh"

module dhcp_lease_record (
  input  logic                       rx_clock,
  input  logic                       state_reset,
  input  logic                       rx_enable,
  input  logic                       packet_end,
  input  dhcp_rx_pkg::ip_addr_t      offered_ip,
  input  dhcp_rx_pkg::dhcp_options_t options,
  input  dhcp_rx_pkg::mac_addr_t     remote_mac,
  input  dhcp_rx_pkg::ip_addr_t      remote_ip,
  output dhcp_rx_pkg::ip_addr_t      ip_accept,
  output dhcp_rx_pkg::seconds_t      lease,
  output dhcp_rx_pkg::ip_addr_t      server_ip,
  output logic                       dhcp_success,
  output logic                       dhcp_failed,
  output logic                       send_request,
  output logic                       is_renewal,
  output dhcp_rx_pkg::mac_addr_t     destination_mac,
  output dhcp_rx_pkg::ip_addr_t      destination_ip
);

  // --------------------------------------------------
  // decision at the end option
  // --------------------------------------------------
  always_ff @(posedge rx_clock) begin
    if (state_reset) begin
      ip_accept       <= '0;
      lease           <= '0;
      server_ip       <= '0;
      dhcp_success    <= 1'b0;
      dhcp_failed     <= 1'b0;
      send_request    <= 1'b0;
      is_renewal      <= 1'b0;
      destination_mac <= `BROADCAST_MAC;  // back to discover
      destination_ip  <= `BROADCAST_IP;
    end else begin
      send_request <= 1'b0;  // single cycle pulse
      if (!rx_enable) begin
        dhcp_success <= 1'b0;
        dhcp_failed  <= 1'b0;
      end else if (packet_end) begin
        if (options.msg_type == `DHCP_MSG_OFFER) begin
          ip_accept    <= offered_ip;
          send_request <= 1'b1;  // ask for the offered address
        end else if (options.msg_type == `DHCP_MSG_ACK) begin
          ip_accept       <= offered_ip;
          lease           <= options.lease;
          server_ip       <= options.server_ip;
          dhcp_success    <= 1'b1;
          dhcp_failed     <= 1'b0;
          is_renewal      <= 1'b1;
          destination_mac <= remote_mac;  // renew unicast to this server
          destination_ip  <= remote_ip;
        end else begin
          dhcp_success <= 1'b0;  // nak or anything else
          dhcp_failed  <= 1'b1;
        end
      end
    end
  end

endmodule

// File: source/dhcp_rx_top.sv
`timescale 1ns/10ps

module dhcp_rx_top (
  input  logic                   rx_clock,
  input  logic                   state_reset,
  input  dhcp_rx_pkg::octet_t    rx_data,
  input  logic                   rx_enable,
  input  logic                   dhcp_rx_active,
  input  dhcp_rx_pkg::xid_t      xid,
  input  dhcp_rx_pkg::mac_addr_t local_mac,
  input  dhcp_rx_pkg::mac_addr_t remote_mac,
  input  dhcp_rx_pkg::ip_addr_t  remote_ip,
  output dhcp_rx_pkg::ip_addr_t  ip_accept,
  output dhcp_rx_pkg::seconds_t  lease,
  output dhcp_rx_pkg::ip_addr_t  server_ip,
  output logic                   dhcp_success,
  output logic                   dhcp_failed,
  output logic                   send_request,
  output logic                   is_renewal,
  output dhcp_rx_pkg::mac_addr_t destination_mac,
  output dhcp_rx_pkg::ip_addr_t  destination_ip
);

  dhcp_rx_pkg::rx_beat_t      beat;
  dhcp_rx_pkg::rx_state_t     state;
  dhcp_rx_pkg::ip_addr_t      offered_ip;
  dhcp_rx_pkg::dhcp_options_t options;
  logic                       header_last;
  logic                       value_last;
  logic                       header_ok;
  logic                       packet_end;

  // a byte counts only while both enables are high
  assign beat = '{data: rx_data, strobe: dhcp_rx_active & rx_enable};

  // --------------------------------------------------
  // packet walk
  // --------------------------------------------------
  dhcp_rx_fsm fsm_i (.rx_clock, .state_reset, .dhcp_rx_active, .beat, .header_last,
                     .header_ok, .value_last, .state, .packet_end);
  dhcp_byte_counter counter_i (.rx_clock, .state_reset, .beat, .state, .header_last,
                               .value_last);
  dhcp_header_check header_i (.rx_clock, .state_reset, .beat, .state, .xid, .local_mac,
                              .header_ok, .offered_ip);
  dhcp_option_decode option_i (.rx_clock, .state_reset, .beat, .state, .value_last,
                               .options);

  // results
  dhcp_lease_record record_i (.rx_clock, .state_reset, .rx_enable, .packet_end, .offered_ip,
                              .options, .remote_mac, .remote_ip, .ip_accept, .lease,
                              .server_ip, .dhcp_success, .dhcp_failed, .send_request,
                              .is_renewal, .destination_mac, .destination_ip);

endmodule

// File: testbench/dhcp_rx_assert.sv
`timescale 1ns/10ps

module dhcp_rx_assert (
  input logic rx_clock,
  input logic state_reset,
  input logic dhcp_success,
  input logic dhcp_failed,
  input logic send_request,
  input logic is_renewal
);

  // --------------------------------------------------
  // result flag rules
  // --------------------------------------------------
  flags_exclusive: assert property (@(posedge rx_clock) disable iff (state_reset)
    !(dhcp_success && dhcp_failed))
    else $error("dhcp_success and dhcp_failed high together");

  request_single: assert property (@(posedge rx_clock) disable iff (state_reset)
    send_request |=> !send_request)  // one cycle pulse only
    else $error("send_request held for two cycles");

  renewal_reset: assert property (@(posedge rx_clock) state_reset |=> !is_renewal)
    else $error("is_renewal still set after state_reset");

endmodule

bind dhcp_rx_top dhcp_rx_assert assert_i (.*);

// File: testbench/dhcp_rx_tb.sv
`timescale 1ns/10ps
`include "dhcp_rx_macros.svh"

module dhcp_rx_tb;

  localparam int ROWS = 7;
  localparam dhcp_rx_pkg::xid_t      XID_VAL = 32'h3903_f326;
  localparam dhcp_rx_pkg::mac_addr_t MAC_VAL = 48'h0200_5e10_2233;  // our chaddr
  localparam dhcp_rx_pkg::mac_addr_t SRV_MAC = 48'h00a0_c914_c829;
  localparam dhcp_rx_pkg::ip_addr_t  SRV_IP  = 32'hc0a8_0001;

  // one packet per row
  // upd 0 keeps addresses, 1 takes yiaddr, 2 takes the ack values
  typedef struct packed {
    logic [95:0]         name;
    dhcp_rx_pkg::octet_t msg_type;
    logic                xid_fault;
    logic                mac_fault;
    logic                reset_before;
    logic                clear_after;   // rx_enable low one cycle after the packet
    logic                exp_send;
    logic                exp_success;
    logic                exp_failed;
    logic                exp_renewal;
    logic [1:0]          upd;
  } row_t;

  row_t table_rows [ROWS] = '{
    '{"offer",   `DHCP_MSG_OFFER, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd1},
    '{"ack",     `DHCP_MSG_ACK,   1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 2'd2},
    '{"xid_bad", `DHCP_MSG_ACK,   1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 2'd0},
    '{"mac_bad", `DHCP_MSG_OFFER, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 2'd0},
    '{"re_offer", `DHCP_MSG_OFFER, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 2'd1},
    '{"nak",     8'd6,            1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 2'd0},
    '{"rst_offr", `DHCP_MSG_OFFER, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd1}
  };

  logic rx_clock;
  logic state_reset;
  logic rx_enable;
  logic dhcp_rx_active;
  logic dhcp_success;
  logic dhcp_failed;
  logic send_request;
  logic is_renewal;
  dhcp_rx_pkg::octet_t    rx_data;
  dhcp_rx_pkg::xid_t      xid;
  dhcp_rx_pkg::mac_addr_t local_mac, remote_mac, destination_mac, exp_dmac;
  dhcp_rx_pkg::ip_addr_t  remote_ip, ip_accept, server_ip, destination_ip;
  dhcp_rx_pkg::ip_addr_t  exp_ip, exp_server, exp_dip;
  dhcp_rx_pkg::seconds_t  lease, exp_lease;

  dhcp_rx_pkg::octet_t   pkt_mem [0:4095];  // all packets back to back
  int                    pkt_first [ROWS];
  int                    pkt_len [ROWS];
  dhcp_rx_pkg::ip_addr_t offer_ip [ROWS];   // random yiaddr per packet
  dhcp_rx_pkg::seconds_t lease_val [ROWS];
  dhcp_rx_pkg::ip_addr_t server_val [ROWS];
  int total_len   = 0;
  int cycle_count = 0;
  int cycle_limit = 0;  // set once the packets are built

  dhcp_rx_top dhcp_rx_top_i (.*);

  initial begin
    rx_clock = 1'b0;
    forever #2 rx_clock = ~rx_clock;  // 4 ns period
  end

  always @(posedge rx_clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the packets never finished", cycle_count);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // --------------------------------------------------
  // packet building
  // --------------------------------------------------
  task automatic push_byte(input dhcp_rx_pkg::octet_t b);
    pkt_mem[total_len] = b;
    total_len = total_len + 1;
  endtask

  task automatic push_option(input dhcp_rx_pkg::octet_t code, input int len,
                             input logic [31:0] value);
    int j;
    push_byte(code);
    push_byte(8'(len));
    for (j = len - 1; j >= 0; j--) push_byte(value[8*j +: 8]);  // msb first
  endtask

  task automatic build_packet(input int r);
    dhcp_rx_pkg::octet_t b;
    int i;
    int extra;
    pkt_first[r]  = total_len;
    offer_ip[r]   = $urandom;
    lease_val[r]  = $urandom;
    server_val[r] = $urandom;
    for (i = 0; i <= `DHCP_HEADER_LAST; i++) begin
      b = 8'(i * 29 + 7);  // filler that also stands in for the cookie
      if (i == 0) b = `DHCP_OP_REPLY;
      if (i >= `DHCP_XID_FIRST && i < `DHCP_XID_FIRST + 4)
        b = XID_VAL[8*(`DHCP_XID_FIRST + 3 - i) +: 8];
      if (i >= `DHCP_YIADDR_FIRST && i < `DHCP_YIADDR_FIRST + 4)
        b = offer_ip[r][8*(`DHCP_YIADDR_FIRST + 3 - i) +: 8];
      if (i >= `DHCP_CHADDR_FIRST && i < `DHCP_CHADDR_FIRST + 6)
        b = MAC_VAL[8*(`DHCP_CHADDR_FIRST + 5 - i) +: 8];
      if (table_rows[r].xid_fault && i == `DHCP_XID_FIRST + 2) b = ~b;
      if (table_rows[r].mac_fault && i == `DHCP_CHADDR_FIRST + 5) b = ~b;
      push_byte(b);
    end
    extra = $urandom_range(3, 1);
    repeat (extra) begin
      push_byte(`DHCP_OPT_PAD);
      push_option(8'd12, $urandom_range(3, 0), $urandom);  // host name option is skipped
    end
    push_option(`DHCP_OPT_MSG_TYPE, 1, {24'd0, table_rows[r].msg_type});
    push_option(`DHCP_OPT_LEASE, 4, lease_val[r]);
    push_byte(`DHCP_OPT_PAD);
    push_option(`DHCP_OPT_SERVER_ID, 4, server_val[r]);
    push_byte(`DHCP_OPT_END);
    pkt_len[r] = total_len - pkt_first[r];
  endtask

  task automatic check_value(input logic [95:0] name, input string what,
                             input logic [47:0] expected, input logic [47:0] actual);
    if (actual !== expected) begin
      $display("ERROR %0s %0s expected %0h actual %0h", name, what, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "output mismatch");
    end
  endtask

  // --------------------------------------------------
  // one table row, driven on falling edges
  // --------------------------------------------------
  task automatic run_row(input int r);
    row_t row;
    int   k;
    int   pulses;
    row    = table_rows[r];
    pulses = 0;
    if (row.reset_before) begin
      state_reset = 1'b1;
      repeat (5) @(negedge rx_clock);
      state_reset = 1'b0;
      exp_ip     = '0;
      exp_lease  = '0;
      exp_server = '0;
      exp_dmac   = `BROADCAST_MAC;
      exp_dip    = `BROADCAST_IP;
      check_value(row.name, "renewal after reset", 1'b0, is_renewal);
      check_value(row.name, "ip_accept after reset", exp_ip, ip_accept);
      check_value(row.name, "dest mac after reset", exp_dmac, destination_mac);
      check_value(row.name, "dest ip after reset", exp_dip, destination_ip);
    end
    dhcp_rx_active = 1'b1;
    for (k = 0; k < pkt_len[r]; k++) begin
      pulses  = pulses + int'(send_request);  // sampled every cycle
      rx_data = pkt_mem[pkt_first[r] + k];
      @(negedge rx_clock);
    end
    pulses = pulses + int'(send_request);
    if (row.upd != 2'd0) exp_ip = offer_ip[r];
    if (row.upd == 2'd2) begin
      exp_lease  = lease_val[r];
      exp_server = server_val[r];
      exp_dmac   = SRV_MAC;
      exp_dip    = SRV_IP;
    end
    check_value(row.name, "send_request", row.exp_send, send_request);
    check_value(row.name, "dhcp_success", row.exp_success, dhcp_success);
    check_value(row.name, "dhcp_failed", row.exp_failed, dhcp_failed);
    check_value(row.name, "is_renewal", row.exp_renewal, is_renewal);
    check_value(row.name, "ip_accept", exp_ip, ip_accept);
    check_value(row.name, "lease", exp_lease, lease);
    check_value(row.name, "server_ip", exp_server, server_ip);
    check_value(row.name, "destination_mac", exp_dmac, destination_mac);
    check_value(row.name, "destination_ip", exp_dip, destination_ip);
    dhcp_rx_active = 1'b0;
    rx_data        = 8'h00;
    rx_enable      = !row.clear_after;
    @(negedge rx_clock);
    pulses    = pulses + int'(send_request);
    rx_enable = 1'b1;
    if (row.clear_after) begin
      check_value(row.name, "success after disable", 1'b0, dhcp_success);
      check_value(row.name, "failed after disable", 1'b0, dhcp_failed);
    end
    check_value(row.name, "request pulse count", row.exp_send, pulses);
    repeat (3) @(negedge rx_clock);  // idle gap
  endtask

  initial begin
    int r;
    void'($urandom(32'h7f93_cf5b));
    state_reset    = 1'b1;
    rx_enable      = 1'b1;
    dhcp_rx_active = 1'b0;
    rx_data        = 8'h00;
    xid            = XID_VAL;
    local_mac      = MAC_VAL;
    remote_mac     = SRV_MAC;
    remote_ip      = SRV_IP;
    exp_ip         = '0;
    exp_lease      = '0;
    exp_server     = '0;
    exp_dmac       = `BROADCAST_MAC;
    exp_dip        = `BROADCAST_IP;
    for (r = 0; r < ROWS; r++) build_packet(r);
    cycle_limit = 2 * total_len + 200;
    repeat (5) @(negedge rx_clock);
    state_reset = 1'b0;
    for (r = 0; r < ROWS; r++) run_row(r);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: list.f
+incdir+source
source/dhcp_rx_pkg.sv
source/dhcp_rx_fsm.sv
source/dhcp_byte_counter.sv
source/dhcp_header_check.sv
source/dhcp_option_decode.sv
source/dhcp_lease_record.sv
source/dhcp_rx_top.sv
testbench/dhcp_rx_assert.sv
testbench/dhcp_rx_tb.sv
